//--- bench/eye_tracker_props.sv
// Concurrent assertions bound into the eye tracker top level to watch the UART and result strobes
`timescale 1ns/1ps
`default_nettype none

module eye_tracker_props (
    input logic cclk,
    input logic rst_n,
    input logic uart_txd,
    input logic tx_busy,
    input logic tx_start,
    input logic result_valid
);

    int unsigned fail_count = 0;    // Read by the testbench at the end of the run

    // --------------------------------------------------
    // UART line and handshake
    // --------------------------------------------------
    idle_line_high: assert property (
        @(posedge cclk) disable iff (!rst_n) !tx_busy |-> uart_txd
    ) else begin
        $error("uart_txd low while the UART is idle");
        fail_count++;
    end

    // Sender must see the UART free before starting a byte
    start_when_free: assert property (
        @(posedge cclk) disable iff (!rst_n) tx_start |-> !tx_busy
    ) else begin
        $error("tx_start while tx_busy is high");
        fail_count++;
    end

    result_pulse: assert property (
        @(posedge cclk) disable iff (!rst_n) result_valid |=> !result_valid
    ) else begin
        $error("result_valid longer than one cycle");
        fail_count++;
    end

    // Line idles high once reset has been applied
    reset_line_high: assert property (
        @(posedge cclk) !rst_n |=> uart_txd
    ) else begin
        $error("uart_txd not high after reset");
        fail_count++;
    end

endmodule

bind eye_tracker_top eye_tracker_props u_eye_tracker_props (
    .cclk(cclk),
    .rst_n(rst_n),
    .uart_txd(uart_txd),
    .tx_busy(tx_busy),
    .tx_start(tx_start),
    .result_valid(result_valid)
);

`default_nettype wire

//--- bench/tb_eye_tracker.sv
// Directed testbench that drives camera frames into the eye tracker and decodes its UART messages
`timescale 1ns/1ps
`default_nettype none

`include "eye_tracker_settings.svh"

module tb_eye_tracker
    import eye_tracker_pkg::*;
();

    localparam int BIT             = `ET_CLKS_PER_BIT;
    localparam int START_WAIT      = 64 * BIT;          // Longest gap before a start bit
    localparam int FRAME_BEATS     = 12 * (16 + 4) + 8; // Largest frame with its blanks
    localparam int NUM_FRAMES      = 8;
    localparam int WATCHDOG_CYCLES =
        2 * (16 + NUM_FRAMES * (FRAME_BEATS + 130 * BIT) + 2 * 200 * BIT);

    logic   cclk;
    logic   rst_n;
    logic   fval;
    logic   lval;
    logic   dval;
    pixel_t data_l;
    pixel_t data_r;
    pixel_t threshold;
    logic   uart_txd;

    pixel_t pix [0:11][0:31];                           // Row, then column
    byte_t  rx_msg [0:`ET_MSG_BYTES-1];
    int     value_errors;
    int     other_errors;
    int     assert_errors;

    eye_tracker_top u_eye_tracker_top (
        .cclk(cclk), .rst_n(rst_n), .fval(fval), .lval(lval), .dval(dval),
        .data_l(data_l), .data_r(data_r), .threshold(threshold), .uart_txd(uart_txd)
    );

    initial begin
        cclk = 1'b0;
        forever #20 cclk = ~cclk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge cclk);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_byte(string name, byte_t got, byte_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_sum_s(string name, sum_s_t got, sum_s_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_sum_sxy(string name, sum_sxy_t got, sum_sxy_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus, UART decoding and reference model
    // --------------------------------------------------
    task automatic fill_frame(int lo, int hi);
        for (int y = 0; y < 12; y++)
            for (int x = 0; x < 32; x++)
                pix[y][x] = pixel_t'($urandom_range(hi, lo));
    endtask

    task automatic drive_frame(int w, int h, pixel_t thr);
        @(posedge cclk);
        threshold <= thr;
        fval      <= 1'b1;
        repeat (2) @(posedge cclk);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x += 2) begin
                lval   <= 1'b1;
                dval   <= 1'b1;
                data_l <= pix[y][x];
                data_r <= pix[y][x+1];
                @(posedge cclk);
            end
            lval   <= 1'b0;
            dval   <= 1'b0;
            data_l <= '0;                               // Would be dark if counted
            data_r <= '0;
            repeat (4) @(posedge cclk);
        end
        fval <= 1'b0;
        @(posedge cclk);
    endtask

    task automatic model_sums(int w, int h, pixel_t thr, output sum_s_t s,
                              output sum_sxy_t sx, output sum_sxy_t sy);
        s  = '0;
        sx = '0;
        sy = '0;
        for (int y = 0; y < h; y++)
            for (int x = 0; x < w; x++)
                if (pix[y][x] < thr) begin              // Strictly below
                    s  = s + 1;
                    sx = sx + sum_sxy_t'(x);
                    sy = sy + sum_sxy_t'(y);
                end
    endtask

    task automatic receive_byte(output byte_t b, output bit ok);
        int wait_cnt;
        ok       = 1'b0;
        b        = '0;
        wait_cnt = 0;
        do begin
            @(negedge cclk);
            wait_cnt++;
        end while (uart_txd !== 1'b0 && wait_cnt < START_WAIT);
        if (uart_txd !== 1'b0) begin
            $display("No start bit on uart_txd within %0d cycles", START_WAIT);
            other_errors++;
            return;
        end
        repeat (BIT / 2 - 1) @(negedge cclk);           // Middle of the start bit
        if (uart_txd !== 1'b0) begin
            $display("Start bit on uart_txd ended before mid-bit");
            other_errors++;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT) @(negedge cclk);
            b[i] = uart_txd;
        end
        repeat (BIT) @(negedge cclk);
        if (uart_txd !== 1'b1) begin
            $display("Stop bit on uart_txd is not high");
            other_errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic receive_message(output bit ok);
        for (int i = 0; i < `ET_MSG_BYTES; i++) begin
            receive_byte(rx_msg[i], ok);
            if (!ok) return;
        end
    endtask

    task automatic check_message(string tag, sum_s_t es, sum_sxy_t esx, sum_sxy_t esy);
        bit ok;
        receive_message(ok);
        if (ok) begin
            check_byte({tag, " header"}, rx_msg[0], `ET_MSG_HEADER);
            check_byte({tag, " sum_s pad"}, rx_msg[1] & 8'hF0, 8'h00);
            check_byte({tag, " sum_sx pad"}, rx_msg[4] & 8'hF0, 8'h00);
            check_byte({tag, " sum_sy pad"}, rx_msg[8] & 8'hF0, 8'h00);
            check_sum_s({tag, " sum_s"}, sum_s_t'({rx_msg[1], rx_msg[2], rx_msg[3]}), es);
            check_sum_sxy({tag, " sum_sx"},
                sum_sxy_t'({rx_msg[4], rx_msg[5], rx_msg[6], rx_msg[7]}), esx);
            check_sum_sxy({tag, " sum_sy"},
                sum_sxy_t'({rx_msg[8], rx_msg[9], rx_msg[10], rx_msg[11]}), esy);
        end
    endtask

    task automatic check_idle(int bits, string what);
        for (int i = 0; i < bits * BIT; i++) begin
            @(negedge cclk);
            if (uart_txd !== 1'b1) begin
                $display("uart_txd left the idle level %s", what);
                other_errors++;
                return;
            end
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_single_pixel();
        fill_frame(200, 200);
        pix[3][6] = 8'd10;                              // Left position
        drive_frame(16, 8, 8'd80);
        check_message("left pixel", 1, 6, 3);
        pix[3][6]  = 8'd200;
        pix[5][11] = 8'd10;                             // Right position
        drive_frame(16, 8, 8'd80);
        check_message("right pixel", 1, 11, 5);
    endtask

    task automatic test_model_frame(string tag, int w, int h, pixel_t thr);
        sum_s_t   s;
        sum_sxy_t sx;
        sum_sxy_t sy;
        model_sums(w, h, thr, s, sx, sy);
        drive_frame(w, h, thr);
        check_message(tag, s, sx, sy);
    endtask

    task automatic test_dropped_result();
        sum_s_t   s;
        sum_sxy_t sx;
        sum_sxy_t sy;
        fill_frame(0, 255);
        model_sums(8, 4, 8'd80, s, sx, sy);
        fork
            begin
                drive_frame(8, 4, 8'd80);
                drive_frame(8, 4, 8'd200);              // Ends while the first is in flight
                drive_frame(8, 4, 8'd200);
            end
            check_message("first of three", s, sx, sy);
        join
        check_idle(200, "after the dropped results");
    endtask

    initial begin
        void'($urandom(22));
        value_errors  = 0;
        other_errors  = 0;
        assert_errors = 0;
        rst_n         = 1'b0;
        fval          = 1'b0;
        lval          = 1'b0;
        dval          = 1'b0;
        data_l        = '0;
        data_r        = '0;
        threshold     = '0;
        repeat (16) @(posedge cclk);
        rst_n <= 1'b1;

        check_idle(200, "after reset");
        fill_frame(80, 255);                            // Nothing below 80
        test_model_frame("empty frame", 16, 8, 8'd80);
        test_single_pixel();
        fill_frame(0, 255);
        test_model_frame("random frame", 32, 12, 8'd80);
        test_model_frame("threshold edge", 32, 12, pix[4][9]);
        test_dropped_result();

        assert_errors = u_eye_tracker_top.u_eye_tracker_props.fail_count;
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/eye_tracker_pkg.sv
design/cl_pixel_input.sv
design/gravity_accum.sv
design/result_sender.sv
design/uart_tx.sv
design/eye_tracker_top.sv
bench/eye_tracker_props.sv
bench/tb_eye_tracker.sv

//--- design/cl_pixel_input.sv
// Camera Link input stage that registers strobes, counts column and row and flags dark pixels
`timescale 1ns/1ps
`default_nettype none

module cl_pixel_input
    import eye_tracker_pkg::*;
(
    input  logic   cclk,
    input  logic   rst_n,
    input  logic   fval,
    input  logic   lval,
    input  logic   dval,
    input  pixel_t data_l,          // Even column
    input  pixel_t data_r,          // Odd column
    input  pixel_t threshold,
    output logic   frame_start,
    output logic   frame_end,
    output logic   beat_valid,
    output logic   hit_l,
    output logic   hit_r,
    output coord_t col,             // Column of the left pixel
    output coord_t row
);

    logic   fval_q;
    logic   lval_q;
    logic   fval_rise;
    logic   lval_rise;
    logic   lval_fall;
    logic   beat_in;
    coord_t col_cnt;
    coord_t row_cnt;
    coord_t col_now;
    coord_t row_now;

    // --------------------------------------------------
    // Edge detection on the raw strobes
    // --------------------------------------------------
    assign fval_rise = fval & ~fval_q;
    assign lval_rise = lval & ~lval_q;
    assign lval_fall = ~lval & lval_q & fval;   // Only line ends inside the frame
    assign beat_in   = fval & lval & dval;

    // Position of the beat at the pins
    assign col_now = lval_rise ? '0 : col_cnt;
    assign row_now = fval_rise ? '0 : row_cnt;

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            beat_valid  <= 1'b0;
            col_cnt     <= '0;
            row_cnt     <= '0;
        end else begin
            fval_q      <= fval;
            lval_q      <= lval;
            frame_start <= fval_rise;
            frame_end   <= ~fval & fval_q;
            beat_valid  <= beat_in;

            // Two pixels per beat
            if (beat_in) begin
                col_cnt <= col_now + coord_t'(2);
            end else if (lval_rise) begin
                col_cnt <= '0;
            end

            if (fval_rise) begin
                row_cnt <= '0;
            end else if (lval_fall) begin
                row_cnt <= row_cnt + coord_t'(1);
            end
        end
    end

    // --------------------------------------------------
    // Beat payload that beat_valid qualifies downstream
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        hit_l <= (data_l < threshold);  // Equal is not dark
        hit_r <= (data_r < threshold);
        col   <= col_now;
        row   <= row_now;
    end

endmodule

`default_nettype wire

//--- design/eye_tracker_pkg.sv
// Shared types of the eye tracker measurement path, imported by the RTL and the testbench
`default_nettype none

`include "eye_tracker_settings.svh"

package eye_tracker_pkg;

    // Data widths
    typedef logic [`ET_PIXEL_WIDTH-1:0]   pixel_t;    // Pixel value or threshold
    typedef logic [`ET_COORD_WIDTH-1:0]   coord_t;    // Column or row
    typedef logic [`ET_SUM_S_WIDTH-1:0]   sum_s_t;
    typedef logic [`ET_SUM_SXY_WIDTH-1:0] sum_sxy_t;
    typedef logic [7:0]                   byte_t;     // One UART character

    // Message sender FSM
    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_LOAD,          // Wait for a free UART, then start a byte
        SEND_WAIT_BUSY,
        SEND_WAIT_DONE
    } sender_state_t;

    // Serializer FSM
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

`default_nettype wire

//--- design/eye_tracker_settings.svh
// Global widths, message layout and UART bit timing of the eye tracker, included where needed
`ifndef EYE_TRACKER_SETTINGS_SVH
`define EYE_TRACKER_SETTINGS_SVH

// --------------------------------------------------
// Video path
// --------------------------------------------------
`define ET_PIXEL_WIDTH      8       // Bits per pixel
`define ET_COORD_WIDTH      10      // Column or row number

// --------------------------------------------------
// Accumulators
// --------------------------------------------------
`define ET_SUM_S_WIDTH      20      // Dark pixel count
`define ET_SUM_SXY_WIDTH    28      // Column sum and row sum

// --------------------------------------------------
// Result message and UART
// --------------------------------------------------
// cclk cycles per serial bit
`define ET_CLKS_PER_BIT     16

`define ET_MSG_HEADER       8'hA5   // Leading sync byte
`define ET_MSG_BYTES        12      // Header + 3 + 4 + 4

`endif

//--- design/eye_tracker_top.sv
// Top level of the eye tracker measurement path from camera pins to the UART line
`timescale 1ns/1ps
`default_nettype none

module eye_tracker_top
    import eye_tracker_pkg::*;
(
    input  logic   cclk,
    input  logic   rst_n,
    input  logic   fval,
    input  logic   lval,
    input  logic   dval,
    input  pixel_t data_l,
    input  pixel_t data_r,
    input  pixel_t threshold,
    output logic   uart_txd
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    logic     frame_start;
    logic     frame_end;
    logic     beat_valid;
    logic     hit_l;
    logic     hit_r;
    coord_t   col;
    coord_t   row;
    logic     result_valid;
    sum_s_t   sum_s;
    sum_sxy_t sum_sx;
    sum_sxy_t sum_sy;
    logic     tx_start;
    byte_t    tx_data;
    logic     tx_busy;

    cl_pixel_input u_cl_pixel_input (
        .cclk(cclk), .rst_n(rst_n),
        .fval(fval), .lval(lval), .dval(dval),
        .data_l(data_l), .data_r(data_r), .threshold(threshold),
        .frame_start(frame_start), .frame_end(frame_end), .beat_valid(beat_valid),
        .hit_l(hit_l), .hit_r(hit_r), .col(col), .row(row)
    );

    gravity_accum u_gravity_accum (
        .cclk(cclk), .rst_n(rst_n),
        .frame_start(frame_start), .frame_end(frame_end), .beat_valid(beat_valid),
        .hit_l(hit_l), .hit_r(hit_r), .col(col), .row(row),
        .result_valid(result_valid), .sum_s(sum_s), .sum_sx(sum_sx), .sum_sy(sum_sy)
    );

    // Results arriving mid-message are dropped here
    result_sender u_result_sender (
        .cclk(cclk), .rst_n(rst_n),
        .result_valid(result_valid), .sum_s(sum_s), .sum_sx(sum_sx), .sum_sy(sum_sy),
        .tx_busy(tx_busy), .tx_start(tx_start), .tx_data(tx_data)
    );

    uart_tx u_uart_tx (
        .cclk(cclk), .rst_n(rst_n),
        .tx_start(tx_start), .tx_data(tx_data),
        .tx_busy(tx_busy), .uart_txd(uart_txd)
    );

endmodule

`default_nettype wire

//--- design/gravity_accum.sv
// Frame accumulator for dark pixel count and coordinate sums, latched and strobed at frame end
`timescale 1ns/1ps
`default_nettype none

module gravity_accum
    import eye_tracker_pkg::*;
(
    input  logic     cclk,
    input  logic     rst_n,
    input  logic     frame_start,
    input  logic     frame_end,
    input  logic     beat_valid,
    input  logic     hit_l,
    input  logic     hit_r,
    input  coord_t   col,
    input  coord_t   row,
    output logic     result_valid,
    output sum_s_t   sum_s,
    output sum_sxy_t sum_sx,
    output sum_sxy_t sum_sy
);

    logic [1:0] inc_s;              // 0, 1 or 2 dark pixels
    sum_sxy_t   inc_sx;
    sum_sxy_t   inc_sy;
    sum_s_t     run_s;
    sum_sxy_t   run_sx;
    sum_sxy_t   run_sy;
    sum_s_t     base_s;
    sum_sxy_t   base_sx;
    sum_sxy_t   base_sy;

    // --------------------------------------------------
    // Per-beat contribution
    // --------------------------------------------------
    assign inc_s  = {1'b0, hit_l} + {1'b0, hit_r};
    assign inc_sx = (hit_l ? sum_sxy_t'(col) : '0)
                  + (hit_r ? sum_sxy_t'(col) + sum_sxy_t'(1) : '0);
    assign inc_sy = (hit_l ? sum_sxy_t'(row) : '0)
                  + (hit_r ? sum_sxy_t'(row) : '0);

    // A beat in the frame start cycle begins a fresh sum
    assign base_s  = frame_start ? '0 : run_s;
    assign base_sx = frame_start ? '0 : run_sx;
    assign base_sy = frame_start ? '0 : run_sy;

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            run_s        <= '0;
            run_sx       <= '0;
            run_sy       <= '0;
            result_valid <= 1'b0;
        end else begin
            if (beat_valid || frame_start) begin
                run_s  <= base_s + (beat_valid ? sum_s_t'(inc_s) : '0);
                run_sx <= base_sx + (beat_valid ? inc_sx : '0);
                run_sy <= base_sy + (beat_valid ? inc_sy : '0);
            end
            result_valid <= frame_end;
        end
    end

    // Result registers hold until the next frame end
    always_ff @(posedge cclk) begin
        if (frame_end) begin
            sum_s  <= run_s;
            sum_sx <= run_sx;
            sum_sy <= run_sy;
        end
    end

endmodule

`default_nettype wire

//--- design/result_sender.sv
// Packs a frame result into the 12-byte message and hands it to the UART one byte at a time
`timescale 1ns/1ps
`default_nettype none

`include "eye_tracker_settings.svh"

module result_sender
    import eye_tracker_pkg::*;
(
    input  logic     cclk,
    input  logic     rst_n,
    input  logic     result_valid,
    input  sum_s_t   sum_s,
    input  sum_sxy_t sum_sx,
    input  sum_sxy_t sum_sy,
    input  logic     tx_busy,
    output logic     tx_start,
    output byte_t    tx_data
);

    localparam int MSG_BITS = `ET_MSG_BYTES * 8;

    sender_state_t       state;
    logic [3:0]          byte_cnt;      // Bytes already handed over
    logic [MSG_BITS-1:0] msg_q;
    logic                load_msg;
    logic                byte_taken;
    logic                last_byte;

    assign load_msg   = (state == SEND_IDLE) && result_valid;
    assign byte_taken = (state == SEND_WAIT_BUSY) && tx_busy;
    assign last_byte  = (byte_cnt == 4'(`ET_MSG_BYTES - 1));

    assign tx_data = msg_q[MSG_BITS-1 -: 8];   // MSB first

    // --------------------------------------------------
    // Message shift register
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (load_msg) begin
            msg_q <= {`ET_MSG_HEADER, 4'h0, sum_s, 4'h0, sum_sx, 4'h0, sum_sy};
        end else if (byte_taken) begin
            msg_q <= {msg_q[MSG_BITS-9:0], 8'h00};
        end
    end

    // --------------------------------------------------
    // Byte handshake FSM
    // --------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state    <= SEND_IDLE;
            byte_cnt <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                SEND_IDLE: begin
                    byte_cnt <= '0;
                    if (result_valid) state <= SEND_LOAD;
                end
                SEND_LOAD: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state    <= SEND_WAIT_BUSY;
                    end
                end
                SEND_WAIT_BUSY: begin
                    if (tx_busy) state <= SEND_WAIT_DONE;   // Byte accepted
                end
                SEND_WAIT_DONE: begin
                    if (!tx_busy) begin
                        if (last_byte) begin
                            state <= SEND_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 4'd1;
                            state    <= SEND_LOAD;
                        end
                    end
                end
                default: state <= SEND_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
// 8N1 UART transmitter timed directly from cclk by a bit-period counter
`timescale 1ns/1ps
`default_nettype none

`include "eye_tracker_settings.svh"

module uart_tx
    import eye_tracker_pkg::*;
(
    input  logic  cclk,
    input  logic  rst_n,
    input  logic  tx_start,
    input  byte_t tx_data,
    output logic  tx_busy,
    output logic  uart_txd
);

    localparam int CNT_W = $clog2(`ET_CLKS_PER_BIT);

    uart_state_t      state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(`ET_CLKS_PER_BIT - 1));

    // Data byte, LSB goes out first
    always_ff @(posedge cclk) begin
        if (state == UART_IDLE && tx_start) begin
            shift_q <= tx_data;
        end else if (state == UART_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state    <= UART_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            tx_busy  <= 1'b0;
            uart_txd <= 1'b1;           // Line idles high
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + CNT_W'(1);
            case (state)
                UART_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_start) begin
                        state    <= UART_START;
                        tx_busy  <= 1'b1;
                        uart_txd <= 1'b0;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        state    <= UART_DATA;
                        bit_idx  <= '0;
                        uart_txd <= shift_q[0];
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_idx  <= bit_idx + 3'd1;
                        uart_txd <= (bit_idx == 3'd7) ? 1'b1 : shift_q[1];
                        if (bit_idx == 3'd7) state <= UART_STOP;
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        state   <= UART_IDLE;
                        tx_busy <= 1'b0;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
